//--- Makefile
# Verilator build and run of the IF stage testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_if_stage
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run stopped before the end of the test"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/fetch_addr_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_cnt (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          pc_set_i,         // Redirect pulse
  input  wire logic [if_pkg::PC_MUX_W-1:0]   pc_mux_i,         // Target select
  input  wire logic [if_pkg::ADDR_W-1:0]     boot_addr_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     jump_target_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     branch_target_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     mepc_i,
  input  wire logic [if_pkg::MTVEC_W-1:0]    mtvec_addr_i,     // Trap base MSBs
  input  wire logic [if_pkg::IRQ_ID_W-1:0]   irq_id_i,         // Vector index
  input  wire logic                          advance_i,        // One word completed
  output logic      [if_pkg::ADDR_W-1:0]     fetch_addr_o,     // Next address to fetch
  output logic                               mtvec_init_o      // Boot pulse for the CSRs
);

  logic [if_pkg::ADDR_W-1:0] target;  // Selected redirect target

  //////////////////////////////////////////////////////////////////////////
  // Redirect target selection
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      if_pkg::PC_BOOT:     target = {boot_addr_i[if_pkg::ADDR_W-1:2], 2'b00};
      if_pkg::PC_JUMP:     target = jump_target_i;
      if_pkg::PC_BRANCH:   target = branch_target_i;
      if_pkg::PC_MRET:     target = mepc_i;                     // Back to the trapped PC
      if_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};      // All exceptions share the base
      if_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:             target = {boot_addr_i[if_pkg::ADDR_W-1:2], 2'b00};  // Unused codes
    endcase
  end

  // CSR block loads mtvec when the core boots
  assign mtvec_init_o = pc_set_i && (pc_mux_i == if_pkg::PC_BOOT);

  //////////////////////////////////////////////////////////////////////////
  // Sequential fetch address
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_o <= '0;
    end else if (pc_set_i) begin
      fetch_addr_o <= target;                       // Redirect wins over stepping
    end else if (advance_i) begin
      fetch_addr_o <= fetch_addr_o + 32'd4;         // Word steps only
    end
  end

endmodule

`default_nettype wire

//--- src/fetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  flush_i,   // Redirect empties the buffer
  fetch_wr_if.fifo   wr,
  fetch_rd_if.fifo   rd
);

  // Entry storage
  logic [if_pkg::INSTR_W-1:0] instr_mem [if_pkg::FIFO_DEPTH];
  logic [if_pkg::ADDR_W-1:0]  pc_mem    [if_pkg::FIFO_DEPTH];
  logic                       err_mem   [if_pkg::FIFO_DEPTH];

  logic [if_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [if_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [if_pkg::FIFO_PTR_W:0]   count;   // One bit wider than the pointers
  logic                          do_push;
  logic                          do_pop;

  assign wr.full  = (count == if_pkg::FIFO_DEPTH);
  assign rd.valid = (count != '0);

  assign do_push = wr.push && !wr.full && !flush_i;  // Push on a flush edge is lost
  assign do_pop  = rd.pop && rd.valid && !flush_i;

  //////////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;         // Wraps at the depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                    // Both or neither
      endcase
    end
  end

  // Payload write, no reset on storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      instr_mem[wr_ptr] <= wr.instr;
      pc_mem[wr_ptr]    <= wr.pc;
      err_mem[wr_ptr]   <= wr.err;
    end
  end

  // Head entry, read combinationally
  assign rd.instr = instr_mem[rd_ptr];
  assign rd.pc    = pc_mem[rd_ptr];
  assign rd.err   = err_mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         pc_set_i,      // Redirect, flushes the stream
  input  wire logic [if_pkg::ADDR_W-1:0]    fetch_addr_i,  // From the address counter
  input  wire logic [if_pkg::INSTR_W-1:0]   wb_dat_i,
  input  wire logic                         wb_ack_i,
  input  wire logic                         wb_err_i,
  output logic                              advance_o,     // Step the counter
  output logic                              wb_cyc_o,
  output logic                              wb_stb_o,
  output logic                              wb_we_o,
  output logic      [3:0]                   wb_sel_o,
  output logic      [if_pkg::ADDR_W-1:0]    wb_adr_o,
  output logic                              busy_o,
  fetch_wr_if.fsm                           wr
);

  logic [if_pkg::FSM_W-1:0]  state_q;
  logic [if_pkg::FSM_W-1:0]  state_d;
  logic                      running_q;  // Set by the first redirect
  logic [if_pkg::ADDR_W-1:0] adr_q;      // Held for the whole cycle
  logic                      term;       // Slave ends the cycle
  logic                      start;      // Open a new cycle

  assign term  = wb_ack_i || wb_err_i;
  assign start = (state_q == if_pkg::FSM_IDLE) && running_q && !wr.full && !pc_set_i;

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      if_pkg::FSM_IDLE: begin
        if (start) state_d = if_pkg::FSM_REQ;       // Room in the buffer
      end
      if_pkg::FSM_REQ: begin
        if (term) begin
          state_d = if_pkg::FSM_IDLE;               // Idle one cycle after each cycle
        end else if (pc_set_i) begin
          state_d = if_pkg::FSM_DISCARD;            // Old stream, finish and drop
        end
      end
      if_pkg::FSM_DISCARD: begin
        if (term) state_d = if_pkg::FSM_IDLE;
      end
      default: state_d = if_pkg::FSM_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= if_pkg::FSM_IDLE;
      running_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (pc_set_i) running_q <= 1'b1;              // No stop request, stream runs on
    end
  end

  // Address latched as the cycle opens, the counter may move under it
  always_ff @(posedge clk) begin
    if (start) adr_q <= fetch_addr_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // Bus and buffer outputs
  //////////////////////////////////////////////////////////////////////////

  assign wb_cyc_o = (state_q != if_pkg::FSM_IDLE);
  assign wb_stb_o = wb_cyc_o;                       // Classic, stb follows cyc
  assign wb_we_o  = 1'b0;                           // Reads only
  assign wb_sel_o = if_pkg::WB_SEL_ALL;
  assign wb_adr_o = adr_q;

  // Kept termination, a redirect in the same cycle drops it
  assign wr.push  = (state_q == if_pkg::FSM_REQ) && term && !pc_set_i;
  assign wr.instr = wb_dat_i;
  assign wr.pc    = adr_q;
  assign wr.err   = wb_err_i;

  assign advance_o = wr.push;
  assign busy_o    = wb_cyc_o || running_q;

endmodule

`default_nettype wire

//--- src/fetch_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read side of the instruction buffer, drained by the IF/ID register
interface fetch_rd_if;

  logic                        valid;  // Head entry present
  logic [if_pkg::INSTR_W-1:0]  instr;  // Head word
  logic [if_pkg::ADDR_W-1:0]   pc;     // Head address
  logic                        err;    // Head bus error flag
  logic                        pop;    // Head leaves on this edge

  modport fifo (
    output valid,
    output instr,
    output pc,
    output err,
    input  pop
  );

  modport pipe (
    input  valid,
    input  instr,
    input  pc,
    input  err,
    output pop
  );

endinterface

`default_nettype wire

//--- src/fetch_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Write side of the instruction buffer, fed by the bus FSM
interface fetch_wr_if;

  logic                        push;   // Write one entry this cycle
  logic [if_pkg::INSTR_W-1:0]  instr;  // Fetched word
  logic [if_pkg::ADDR_W-1:0]   pc;     // Address it came from
  logic                        err;    // Bus error on that cycle
  logic                        full;   // No free entry

  modport fsm (
    output push,
    output instr,
    output pc,
    output err,
    input  full
  );

  modport fifo (
    input  push,
    input  instr,
    input  pc,
    input  err,
    output full
  );

endinterface

`default_nettype wire

//--- src/if_id_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_pipe (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         flush_i,     // Redirect drops the held word
  input  wire logic                         halt_i,      // Freeze loading
  input  wire logic                         id_ready_i,  // Decode takes the word
  fetch_rd_if.pipe                          rd,
  output logic                              if_valid_o,
  output logic      [if_pkg::INSTR_W-1:0]   instr_o,
  output logic      [if_pkg::ADDR_W-1:0]    pc_o,
  output logic                              bus_err_o
);

  logic room;  // Register empty or being consumed

  assign room   = !if_valid_o || id_ready_i;
  assign rd.pop = rd.valid && room && !halt_i && !flush_i;

  //////////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid_o <= 1'b0;
      instr_o    <= if_pkg::NOP_INSTR;
      pc_o       <= '0;
      bus_err_o  <= 1'b0;
    end else if (flush_i) begin
      if_valid_o <= 1'b0;                           // Old stream never reaches decode
    end else if (rd.pop) begin
      if_valid_o <= 1'b1;
      instr_o    <= rd.instr;
      pc_o       <= rd.pc;
      bus_err_o  <= rd.err;
    end else if (id_ready_i) begin
      if_valid_o <= 1'b0;                           // Consumed, nothing to replace it
    end
  end

endmodule

`default_nettype wire

//--- src/if_pkg.sv
`default_nettype none

package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W   = 32;  // Fetch address width
  localparam int INSTR_W  = 32;  // Instruction word width
  localparam int MTVEC_W  = 25;  // Trap base, sits above 7 zero bits
  localparam int IRQ_ID_W = 5;   // Vectored interrupt id
  localparam int PC_MUX_W = 3;   // Redirect selector

  ////////////////////////////////////////////////////////////////////////////
  // Redirect selector codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [PC_MUX_W-1:0] PC_BOOT     = 3'd0;  // Boot address, word aligned
  localparam logic [PC_MUX_W-1:0] PC_JUMP     = 3'd1;  // Jump target from ID
  localparam logic [PC_MUX_W-1:0] PC_BRANCH   = 3'd2;  // Branch target from EX
  localparam logic [PC_MUX_W-1:0] PC_MRET     = 3'd3;  // Return to mepc
  localparam logic [PC_MUX_W-1:0] PC_TRAP_EXC = 3'd4;  // Exception base
  localparam logic [PC_MUX_W-1:0] PC_TRAP_IRQ = 3'd5;  // Vectored interrupt entry

  // Instruction buffer geometry
  localparam int FIFO_DEPTH = 2;
  localparam int FIFO_PTR_W = 1;

  // Bus FSM state codes
  localparam int                FSM_W       = 2;
  localparam logic [FSM_W-1:0]  FSM_IDLE    = 2'd0;  // No cycle on the bus
  localparam logic [FSM_W-1:0]  FSM_REQ     = 2'd1;  // Cycle whose data is kept
  localparam logic [FSM_W-1:0]  FSM_DISCARD = 2'd2;  // Stale cycle, data dropped

  // Reset and bus constants
  localparam logic [INSTR_W-1:0] NOP_INSTR  = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [3:0]         WB_SEL_ALL = 4'hF;           // Full word read

endpackage

`default_nettype wire

//--- src/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  // Redirect targets
  input  wire logic [if_pkg::ADDR_W-1:0]     boot_addr_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     jump_target_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     branch_target_i,
  input  wire logic [if_pkg::ADDR_W-1:0]     mepc_i,
  input  wire logic [if_pkg::MTVEC_W-1:0]    mtvec_addr_i,
  input  wire logic [if_pkg::IRQ_ID_W-1:0]   irq_id_i,

  // Control side
  input  wire logic                          pc_set_i,
  input  wire logic [if_pkg::PC_MUX_W-1:0]   pc_mux_i,
  input  wire logic                          halt_i,
  input  wire logic                          id_ready_i,

  // Wishbone classic master
  input  wire logic [if_pkg::INSTR_W-1:0]    wb_dat_i,
  input  wire logic                          wb_ack_i,
  input  wire logic                          wb_err_i,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic                               wb_we_o,
  output logic      [3:0]                    wb_sel_o,
  output logic      [if_pkg::ADDR_W-1:0]     wb_adr_o,

  // To decode
  output logic                               if_valid_o,
  output logic      [if_pkg::INSTR_W-1:0]    instr_o,
  output logic      [if_pkg::ADDR_W-1:0]     pc_o,
  output logic                               bus_err_o,
  output logic                               if_busy_o,
  output logic                               mtvec_init_o
);

  logic [if_pkg::ADDR_W-1:0] fetch_addr;  // Next word address
  logic                      advance;     // Counter step

  fetch_wr_if wr_bus ();                   // FSM into buffer
  fetch_rd_if rd_bus ();                   // Buffer into IF/ID

  ////////////////////////////////////////////////////////////////////////////
  // Address counter and bus master
  ////////////////////////////////////////////////////////////////////////////

  fetch_addr_cnt i_addr_cnt (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_id_i        (irq_id_i),
    .advance_i       (advance),
    .fetch_addr_o    (fetch_addr),
    .mtvec_init_o    (mtvec_init_o)
  );

  fetch_fsm i_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_set_i     (pc_set_i),
    .fetch_addr_i (fetch_addr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i),
    .advance_o    (advance),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_sel_o     (wb_sel_o),
    .wb_adr_o     (wb_adr_o),
    .busy_o       (if_busy_o),
    .wr           (wr_bus.fsm)
  );

  // Buffer and output register, both flushed by a redirect
  fetch_fifo i_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (pc_set_i),
    .wr      (wr_bus.fifo),
    .rd      (rd_bus.fifo)
  );

  if_id_pipe i_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (pc_set_i),
    .halt_i     (halt_i),
    .id_ready_i (id_ready_i),
    .rd         (rd_bus.pipe),
    .if_valid_o (if_valid_o),
    .instr_o    (instr_o),
    .pc_o       (pc_o),
    .bus_err_o  (bus_err_o)
  );

endmodule

`default_nettype wire

//--- verification/if_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage_props (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         pc_set_i,     // Flush overrides the hold
  input  wire logic                         id_ready_i,
  input  wire logic                         wb_cyc_o,
  input  wire logic                         wb_stb_o,
  input  wire logic                         wb_we_o,
  input  wire logic [3:0]                   wb_sel_o,
  input  wire logic [if_pkg::ADDR_W-1:0]    wb_adr_o,
  input  wire logic                         wb_ack_i,
  input  wire logic                         wb_err_i,
  input  wire logic                         if_valid_o,
  input  wire logic [if_pkg::INSTR_W-1:0]   instr_o,
  input  wire logic [if_pkg::ADDR_W-1:0]    pc_o,
  input  wire logic                         bus_err_o
);

  logic term;  // Slave ends the cycle

  assign term = wb_ack_i || wb_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone classic master
  ////////////////////////////////////////////////////////////////////////////

  a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb_o |-> wb_cyc_o)
    else $error("stb high without cyc");

  a_read_word: assert property (@(posedge clk) disable iff (!rst_n)
    wb_cyc_o |-> (!wb_we_o && wb_sel_o == if_pkg::WB_SEL_ALL))
    else $error("Cycle is not a full word read");

  // Address held until ack or err
  a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_o && !term) |=> (wb_stb_o && $stable(wb_adr_o)))
    else $error("Address or stb changed before termination");

  a_gap: assert property (@(posedge clk) disable iff (!rst_n) (wb_stb_o && term) |=> !wb_stb_o)
    else $error("New request right after termination");

  a_reset: assert property (@(posedge clk) !rst_n |-> !wb_stb_o)
    else $error("stb high during reset");

  // IF/ID output under back-pressure
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (if_valid_o && !id_ready_i && !pc_set_i)
    |=> (if_valid_o && $stable(instr_o) && $stable(pc_o) && $stable(bus_err_o)))
    else $error("IF/ID output changed while decode was stalled");

endmodule

bind if_stage if_stage_props i_props (.*);

`default_nettype wire

//--- verification/tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  localparam int          NUM_ROWS    = 10;
  localparam int          TIMEOUT     = 200;            // Cycles per wait
  localparam int          HALT_CYCLES = 12;
  localparam logic [31:0] DATA_KEY    = 32'h5A5A_0000;  // Memory word is address XOR key

  typedef struct packed {
    logic [if_pkg::PC_MUX_W-1:0] mux;
    logic [if_pkg::ADDR_W-1:0]   tgt;        // Driven on the selected input only
    logic [if_pkg::IRQ_ID_W-1:0] irq;
    logic [7:0]                  words;      // Words to collect
    logic [if_pkg::ADDR_W-1:0]   first;      // Expected first pc_o
    logic                        in_flight;  // Redirect while stb is high
    logic [7:0]                  halt_at;    // Halt point in words (FF means none)
  } row_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic [if_pkg::ADDR_W-1:0]    boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  logic [if_pkg::MTVEC_W-1:0]   mtvec_addr_i;
  logic [if_pkg::IRQ_ID_W-1:0]  irq_id_i;
  logic [if_pkg::PC_MUX_W-1:0]  pc_mux_i;
  logic                         pc_set_i, halt_i, id_ready_i;
  logic [if_pkg::INSTR_W-1:0]   wb_dat_i, instr_o;
  logic                         wb_ack_i, wb_err_i;
  logic                         wb_cyc_o, wb_stb_o, wb_we_o;
  logic [3:0]                   wb_sel_o;
  logic [if_pkg::ADDR_W-1:0]    wb_adr_o, pc_o;
  logic                         if_valid_o, bus_err_o, if_busy_o, mtvec_init_o;

  logic [15:0]  lfsr;      // Shared by the bus model and the decode side
  logic [1:0]   waits;     // Wait states left in this bus cycle
  logic         in_cycle;  // Delay already drawn
  row_t         rows [NUM_ROWS];

  always #10 clk = ~clk;

  if_stage i_dut (.*);

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11
  endfunction

  function automatic logic in_err_window(input logic [if_pkg::ADDR_W-1:0] a);
    return (a >= 32'h0000_F000) && (a <= 32'h0000_F00F);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_in_failure();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_addr(input string name, input logic [if_pkg::ADDR_W-1:0] got,
                            input logic [if_pkg::ADDR_W-1:0] want);
    if (got !== want) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
      end_in_failure();
    end
  endtask

  task automatic check_instr(input string name, input logic [if_pkg::INSTR_W-1:0] got,
                             input logic [if_pkg::INSTR_W-1:0] want);
    if (got !== want) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
      end_in_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
      end_in_failure();
    end
  endtask

  task automatic check_word(input logic [if_pkg::ADDR_W-1:0] want_pc);
    check_addr("pc_o", pc_o, want_pc);
    check_flag("bus_err_o", bus_err_o, in_err_window(want_pc));
    check_flag("if_busy_o", if_busy_o, 1'b1);               // Stream running once redirected
    if (!in_err_window(want_pc)) begin
      check_instr("instr_o", instr_o, want_pc ^ DATA_KEY);  // Data undefined on err
    end
  endtask

  // Word accepted by decode on the next rising edge
  task automatic take_word(input logic [if_pkg::ADDR_W-1:0] want_pc);
    int t;
    t = 0;
    @(negedge clk);
    while (!(if_valid_o && id_ready_i) && t < TIMEOUT) begin
      t = t + 1;
      @(negedge clk);
    end
    if (!(if_valid_o && id_ready_i)) begin
      $display("Timeout: no word accepted for address 0x%h", want_pc);
      end_in_failure();
    end else begin
      check_word(want_pc);
    end
  endtask

  task automatic wait_for_stb();
    int t;
    t = 0;
    @(negedge clk);
    while (!wb_stb_o && t < TIMEOUT) begin
      t = t + 1;
      @(negedge clk);
    end
    if (!wb_stb_o) begin
      $display("Timeout: no bus cycle started before the redirect");
      end_in_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic redirect(input row_t row);
    @(posedge clk);
    // Decoys on the other inputs so a wrong selection shows in pc_o
    boot_addr_i     <= (row.mux == if_pkg::PC_BOOT)   ? row.tgt : 32'h0000_3003;
    jump_target_i   <= (row.mux == if_pkg::PC_JUMP)   ? row.tgt : 32'h0000_3400;
    branch_target_i <= (row.mux == if_pkg::PC_BRANCH) ? row.tgt : 32'h0000_3800;
    mepc_i          <= (row.mux == if_pkg::PC_MRET)   ? row.tgt : 32'h0000_3C00;
    mtvec_addr_i    <= (row.mux >= if_pkg::PC_TRAP_EXC) ? row.tgt[if_pkg::MTVEC_W-1:0]
                                                        : 25'h00_0079;
    irq_id_i        <= row.irq;
    pc_mux_i        <= row.mux;
    pc_set_i        <= 1'b1;
    @(negedge clk);
    check_flag("mtvec_init_o", mtvec_init_o, row.mux == if_pkg::PC_BOOT);
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic hold_halt(inout logic [if_pkg::ADDR_W-1:0] want_pc, output int taken);
    taken = 0;
    @(posedge clk);
    halt_i <= 1'b1;
    repeat (HALT_CYCLES) begin
      @(negedge clk);
      if (if_valid_o && id_ready_i) begin
        check_word(want_pc);                    // Only the word already in IF/ID
        want_pc = want_pc + 32'd4;
        taken   = taken + 1;
      end
    end
    if (taken > 1 || if_valid_o) begin
      $display("Stage kept delivering words while halted");
      end_in_failure();
    end
    @(posedge clk);
    halt_i <= 1'b0;
  endtask

  // Wishbone memory and decode side drawing from one LFSR
  always @(posedge clk) begin
    if (rst_n) begin
      if (!id_ready_i) begin
        id_ready_i <= 1'b1;                     // At most one stall cycle
      end else begin
        lfsr = lfsr_step(lfsr);
        id_ready_i <= lfsr[0];
      end
      if (wb_ack_i || wb_err_i) begin
        wb_ack_i <= 1'b0;                       // Cycle ends on this edge
        wb_err_i <= 1'b0;
        in_cycle = 1'b0;
      end else if (wb_stb_o) begin
        if (!in_cycle) begin
          lfsr     = lfsr_step(lfsr);
          waits[0] = lfsr[0];
          lfsr     = lfsr_step(lfsr);
          waits[1] = lfsr[0];
          in_cycle = 1'b1;
        end
        if (waits == 2'd0) begin
          wb_dat_i <= wb_adr_o ^ DATA_KEY;
          wb_ack_i <= !in_err_window(wb_adr_o);
          wb_err_i <= in_err_window(wb_adr_o);
        end else begin
          waits = waits - 2'd1;
        end
      end
    end
  end

  initial begin
    int                        r;
    int                        got;
    int                        taken;
    logic                      halted;
    logic [if_pkg::ADDR_W-1:0] want_pc;
    // Selector, target, irq, words, first pc, in flight, halt point
    rows[0] = '{if_pkg::PC_BOOT,     32'h0000_0103, 5'd0,  8'd6, 32'h0000_0100, 1'b0, 8'hFF};
    rows[1] = '{if_pkg::PC_JUMP,     32'h0000_0400, 5'd0,  8'd5, 32'h0000_0400, 1'b1, 8'hFF};
    rows[2] = '{if_pkg::PC_BRANCH,   32'h0000_0824, 5'd0,  8'd6, 32'h0000_0824, 1'b1, 8'd2};
    rows[3] = '{if_pkg::PC_MRET,     32'h0000_0C08, 5'd0,  8'd5, 32'h0000_0C08, 1'b1, 8'hFF};
    rows[4] = '{if_pkg::PC_TRAP_EXC, 32'h0000_0021, 5'd0,  8'd4, 32'h0000_1080, 1'b0, 8'hFF};
    rows[5] = '{if_pkg::PC_TRAP_IRQ, 32'h0000_0021, 5'd3,  8'd3, 32'h0000_108C, 1'b1, 8'hFF};
    rows[6] = '{if_pkg::PC_TRAP_IRQ, 32'h0000_0040, 5'd31, 8'd3, 32'h0000_207C, 1'b0, 8'hFF};
    rows[7] = '{if_pkg::PC_JUMP,     32'h0000_F008, 5'd0,  8'd4, 32'h0000_F008, 1'b1, 8'hFF};
    rows[8] = '{if_pkg::PC_BRANCH,   32'h0000_0200, 5'd0,  8'd8, 32'h0000_0200, 1'b0, 8'd3};
    rows[9] = '{if_pkg::PC_TRAP_IRQ, 32'h0000_0021, 5'd0,  8'd2, 32'h0000_1080, 1'b1, 8'hFF};
    lfsr            = 16'd43679;
    waits           = 2'd0;
    in_cycle        = 1'b0;
    rst_n           = 1'b0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    pc_mux_i        = if_pkg::PC_BOOT;
    pc_set_i        = 1'b0;
    halt_i          = 1'b0;
    id_ready_i      = 1'b1;
    wb_dat_i        = '0;
    wb_ack_i        = 1'b0;
    wb_err_i        = 1'b0;

    repeat (15) @(posedge clk);
    @(negedge clk);
    check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
    check_flag("if_valid_o", if_valid_o, 1'b0);
    check_flag("bus_err_o", bus_err_o, 1'b0);
    check_flag("if_busy_o", if_busy_o, 1'b0);
    check_flag("mtvec_init_o", mtvec_init_o, 1'b0);  // Boot selector without a pulse
    check_addr("pc_o", pc_o, '0);
    check_instr("instr_o", instr_o, if_pkg::NOP_INSTR);
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_flag("wb_stb_o", wb_stb_o, 1'b0);   // Idle until the first redirect
      check_flag("if_busy_o", if_busy_o, 1'b0);
    end

    for (r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].in_flight) begin
        wait_for_stb();
      end
      redirect(rows[r]);
      want_pc = rows[r].first;
      got     = 0;
      halted  = 1'b0;
      while (got < int'(rows[r].words)) begin
        if (!halted && got == int'(rows[r].halt_at)) begin
          hold_halt(want_pc, taken);
          got    = got + taken;
          halted = 1'b1;
        end else begin
          take_word(want_pc);
          want_pc = want_pc + 32'd4;
          got     = got + 1;
        end
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/if_pkg.sv
src/fetch_wr_if.sv
src/fetch_rd_if.sv
src/fetch_addr_cnt.sv
src/fetch_fsm.sv
src/fetch_fifo.sv
src/if_id_pipe.sv
src/if_stage.sv
verification/if_stage_props.sv
verification/tb_if_stage.sv
